// File: Makefile
TOP := tb_mem_backend

sim:
	verilator --binary --timing --timescale 1ns/1ps -f sim.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^Test OK$$"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: common/backend_consts.svh
`ifndef BACKEND_CONSTS_SVH
`define BACKEND_CONSTS_SVH

// data RAM depth in words, must be a power of two
`define RAM_WORDS 256

// access type codes
// bits 1:0 give the size, bit 2 set means unsigned
`define MT_W  3'b000
`define MT_H  3'b001
`define MT_B  3'b010
`define MT_HU 3'b101
`define MT_BU 3'b110

`endif

// File: common/lsu_pkg.sv
`default_nettype none

`include "backend_consts.svh"

package lsu_pkg;

    typedef logic [31:0] word_t;        // data word or byte address
    typedef logic [2:0]  mem_type_t;    // size in [1:0], unsigned in [2]
    typedef logic [1:0]  addr_low_t;    // byte offset in a word
    typedef logic [3:0]  byte_en_t;     // one bit per byte lane

    // word index into the data RAM
    typedef logic [$clog2(`RAM_WORDS)-1:0] ram_idx_t;

endpackage

`default_nettype wire

// File: common/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    typedef logic [4:0]  reg_idx_t;     // architectural register number
    typedef logic [31:0] pc_t;          // instruction address, trace only

endpackage

`default_nettype wire

// File: design/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_consts.svh"

module data_ram import lsu_pkg::*; (
    input  wire      clk,
    input  wire      ex_fire,
    input  byte_en_t ram_we,
    input  word_t    ram_wdata,
    input  ram_idx_t ram_idx,
    output word_t    ram_rdata
);

    word_t mem [0:`RAM_WORDS-1];

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (ram_we[i]) begin
                mem[ram_idx][i*8 +: 8] <= ram_wdata[i*8 +: 8];
            end
        end
    end

    // old word comes back on a store, read only on fire
    always_ff @(posedge clk) begin
        if (ex_fire) begin
            ram_rdata <= mem[ram_idx];
        end
    end

endmodule

`default_nettype wire

// File: design/mem_backend.sv
`timescale 1ns/1ps
`default_nettype none

module mem_backend import lsu_pkg::*, pipe_pkg::*; (
    input  wire       clk,
    input  wire       resetn,
    input  wire       ex_valid,
    input  pc_t       ex_pc,
    input  wire       ex_gr_we,
    input  wire       ex_res_from_mem,
    input  wire       ex_mem_we,
    input  mem_type_t ex_mem_type,
    input  word_t     ex_alu_result,
    input  word_t     ex_store_data,
    input  reg_idx_t  ex_dest,
    input  wire       ex_ertn,
    input  wire       commit_stall,
    output logic      ex_allowin,
    output logic      ertn_flush,
    output logic      mem_fwd_valid,
    output reg_idx_t  mem_fwd_dest,
    output word_t     mem_fwd_data,
    output logic      rf_we,
    output reg_idx_t  rf_waddr,
    output word_t     rf_wdata,
    output pc_t       wb_pc
);

    logic     ex_fire;
    logic     mem_to_wb;
    logic     mem_valid;
    logic     wb_valid;
    byte_en_t ram_we;
    word_t    ram_wdata;
    ram_idx_t ram_idx;
    word_t    ram_rdata;
    pc_t      mem_pc;
    logic     mem_gr_we;
    reg_idx_t mem_dest;
    word_t    mem_result;
    logic     mem_ertn;

    pipe_ctrl u_pipe_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .ex_valid     (ex_valid),
        .mem_ertn     (mem_ertn),
        .commit_stall (commit_stall),
        .ex_allowin   (ex_allowin),
        .ex_fire      (ex_fire),
        .mem_to_wb    (mem_to_wb),
        .mem_valid    (mem_valid),
        .wb_valid     (wb_valid),
        .ertn_flush   (ertn_flush)
    );

    store_align u_store_align (
        .ex_fire       (ex_fire),
        .ex_mem_we     (ex_mem_we),
        .ex_mem_type   (ex_mem_type),
        .ex_alu_result (ex_alu_result),
        .ex_store_data (ex_store_data),
        .ram_we        (ram_we),
        .ram_wdata     (ram_wdata),
        .ram_idx       (ram_idx)
    );

    data_ram u_data_ram (
        .clk       (clk),
        .ex_fire   (ex_fire),
        .ram_we    (ram_we),
        .ram_wdata (ram_wdata),
        .ram_idx   (ram_idx),
        .ram_rdata (ram_rdata)
    );

    mem_stage u_mem_stage (
        .clk             (clk),
        .ex_fire         (ex_fire),
        .mem_valid       (mem_valid),
        .ex_pc           (ex_pc),
        .ex_gr_we        (ex_gr_we),
        .ex_res_from_mem (ex_res_from_mem),
        .ex_mem_type     (ex_mem_type),
        .ex_alu_result   (ex_alu_result),
        .ex_dest         (ex_dest),
        .ex_ertn         (ex_ertn),
        .ram_rdata       (ram_rdata),
        .mem_pc          (mem_pc),
        .mem_gr_we       (mem_gr_we),
        .mem_dest        (mem_dest),
        .mem_result      (mem_result),
        .mem_ertn        (mem_ertn),
        .mem_fwd_valid   (mem_fwd_valid),
        .mem_fwd_dest    (mem_fwd_dest),
        .mem_fwd_data    (mem_fwd_data)
    );

    wb_stage u_wb_stage (
        .clk          (clk),
        .mem_to_wb    (mem_to_wb),
        .wb_valid     (wb_valid),
        .commit_stall (commit_stall),
        .mem_pc       (mem_pc),
        .mem_gr_we    (mem_gr_we),
        .mem_dest     (mem_dest),
        .mem_result   (mem_result),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .wb_pc        (wb_pc)
    );

endmodule

`default_nettype wire

// File: design/pipe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl (
    input  wire  clk,
    input  wire  resetn,
    input  wire  ex_valid,
    input  wire  mem_ertn,
    input  wire  commit_stall,
    output logic ex_allowin,
    output logic ex_fire,
    output logic mem_to_wb,
    output logic mem_valid,
    output logic wb_valid,
    output logic ertn_flush
);

    logic wb_ready_go;
    logic wb_allowin;

    assign wb_ready_go  = ~commit_stall;    // retire port not ready

    assign wb_allowin = ~wb_valid | wb_ready_go;
    assign ex_allowin = ~mem_valid | wb_allowin;

    assign ex_fire   = ex_valid & ex_allowin;
    assign mem_to_wb = mem_valid & wb_allowin;

    assign ertn_flush = mem_valid & mem_ertn;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_valid <= 1'b0;
        end else if (ex_allowin) begin
            mem_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (wb_allowin) begin
            wb_valid <= mem_valid;   // bubble when MEM empty
        end
    end

endmodule

`default_nettype wire

// File: design/store_align.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_consts.svh"

module store_align import lsu_pkg::*; (
    input  wire       ex_fire,
    input  wire       ex_mem_we,
    input  mem_type_t ex_mem_type,
    input  word_t     ex_alu_result,
    input  word_t     ex_store_data,
    output byte_en_t  ram_we,
    output word_t     ram_wdata,
    output ram_idx_t  ram_idx
);

    localparam int IDX_W = $bits(ram_idx_t);

    addr_low_t addr_low;
    byte_en_t  lane_en;

    assign addr_low = ex_alu_result[1:0];
    assign ram_idx  = ex_alu_result[IDX_W+1:2];     // upper address bits dropped

    always_comb begin
        case (ex_mem_type)
            `MT_H, `MT_HU: begin
                ram_wdata = {2{ex_store_data[15:0]}};
                lane_en   = addr_low[1] ? 4'b1100 : 4'b0011;
            end
            `MT_B, `MT_BU: begin
                ram_wdata = {4{ex_store_data[7:0]}};
                lane_en   = 4'b0001 << addr_low;
            end
            default: begin                          // word
                ram_wdata = ex_store_data;
                lane_en   = 4'b1111;
            end
        endcase
    end

    assign ram_we = (ex_fire & ex_mem_we) ? lane_en : 4'b0000;

endmodule

`default_nettype wire

// File: design/wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module wb_stage import lsu_pkg::*, pipe_pkg::*; (
    input  wire      clk,
    input  wire      mem_to_wb,
    input  wire      wb_valid,
    input  wire      commit_stall,
    input  pc_t      mem_pc,
    input  wire      mem_gr_we,
    input  reg_idx_t mem_dest,
    input  word_t    mem_result,
    output logic     rf_we,
    output reg_idx_t rf_waddr,
    output word_t    rf_wdata,
    output pc_t      wb_pc
);

    logic wb_gr_we;

    always_ff @(posedge clk) begin
        if (mem_to_wb) begin
            wb_pc    <= mem_pc;
            wb_gr_we <= mem_gr_we;
            rf_waddr <= mem_dest;
            rf_wdata <= mem_result;
        end
    end

    // write lands on the cycle the retire port is ready
    assign rf_we = wb_valid & wb_gr_we & ~commit_stall;

endmodule

`default_nettype wire

// File: mem_stage/load_align.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_consts.svh"

module load_align import lsu_pkg::*; (
    input  word_t     ram_rdata,
    input  mem_type_t mem_type,
    input  addr_low_t addr_low,
    output word_t     load_data
);

    logic [15:0] half_data;
    logic [7:0]  byte_data;

    assign half_data = addr_low[1] ? ram_rdata[31:16] : ram_rdata[15:0];

    always_comb begin
        case (addr_low)
            2'b00:   byte_data = ram_rdata[7:0];
            2'b01:   byte_data = ram_rdata[15:8];
            2'b10:   byte_data = ram_rdata[23:16];
            default: byte_data = ram_rdata[31:24];
        endcase
    end

    always_comb begin
        case (mem_type)
            `MT_W:   load_data = ram_rdata;
            `MT_H:   load_data = {{16{half_data[15]}}, half_data};
            `MT_HU:  load_data = {16'h0000, half_data};
            `MT_B:   load_data = {{24{byte_data[7]}}, byte_data};
            `MT_BU:  load_data = {24'h000000, byte_data};
            default: load_data = ram_rdata;     // unused codes act as word
        endcase
    end

endmodule

`default_nettype wire

// File: mem_stage/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage import lsu_pkg::*, pipe_pkg::*; (
    input  wire       clk,
    input  wire       ex_fire,
    input  wire       mem_valid,
    input  pc_t       ex_pc,
    input  wire       ex_gr_we,
    input  wire       ex_res_from_mem,
    input  mem_type_t ex_mem_type,
    input  word_t     ex_alu_result,
    input  reg_idx_t  ex_dest,
    input  wire       ex_ertn,
    input  word_t     ram_rdata,
    output pc_t       mem_pc,
    output logic      mem_gr_we,
    output reg_idx_t  mem_dest,
    output word_t     mem_result,
    output logic      mem_ertn,
    output logic      mem_fwd_valid,
    output reg_idx_t  mem_fwd_dest,
    output word_t     mem_fwd_data
);

    logic      mem_res_from_mem;
    mem_type_t mem_type;
    addr_low_t mem_addr_low;
    word_t     mem_alu_result;
    word_t     load_data;

    always_ff @(posedge clk) begin
        if (ex_fire) begin
            mem_pc           <= ex_pc;
            mem_gr_we        <= ex_gr_we;
            mem_res_from_mem <= ex_res_from_mem;
            mem_type         <= ex_mem_type;
            mem_addr_low     <= ex_alu_result[1:0];
            mem_alu_result   <= ex_alu_result;
            mem_dest         <= ex_dest;
            mem_ertn         <= ex_ertn;
        end
    end

    load_align u_load_align (
        .ram_rdata (ram_rdata),
        .mem_type  (mem_type),
        .addr_low  (mem_addr_low),
        .load_data (load_data)
    );

    assign mem_result = mem_res_from_mem ? load_data : mem_alu_result;

    // bypass back to decode
    assign mem_fwd_valid = mem_valid & mem_gr_we;
    assign mem_fwd_dest  = mem_dest;
    assign mem_fwd_data  = mem_result;

endmodule

`default_nettype wire

// File: sim.f
+incdir+common
common/lsu_pkg.sv
common/pipe_pkg.sv
design/pipe_ctrl.sv
design/store_align.sv
design/data_ram.sv
mem_stage/load_align.sv
mem_stage/mem_stage.sv
design/wb_stage.sv
design/mem_backend.sv
testbench/tb_clock.sv
testbench/tb_mem_backend.sv

// File: testbench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;      // 4 ns period
    end

endmodule

`default_nettype wire

// File: testbench/tb_mem_backend.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_consts.svh"

module tb_mem_backend import lsu_pkg::*, pipe_pkg::*; ();

    localparam int MAX_ENTRIES  = 64;
    localparam int ACCEPT_LIMIT = 40;
    localparam int DRAIN_LIMIT  = 200;

    logic      clk;
    logic      resetn;
    logic      ex_valid;
    pc_t       ex_pc;
    logic      ex_gr_we;
    logic      ex_res_from_mem;
    logic      ex_mem_we;
    mem_type_t ex_mem_type;
    word_t     ex_alu_result;
    word_t     ex_store_data;
    reg_idx_t  ex_dest;
    logic      ex_ertn;
    logic      commit_stall;
    logic      ex_allowin;
    logic      ertn_flush;
    logic      mem_fwd_valid;
    reg_idx_t  mem_fwd_dest;
    word_t     mem_fwd_data;
    logic      rf_we;
    reg_idx_t  rf_waddr;
    word_t     rf_wdata;
    pc_t       wb_pc;

    // stimulus table with expected data filled in on accept
    mem_type_t t_type     [MAX_ENTRIES];
    logic      t_store    [MAX_ENTRIES];
    word_t     t_addr     [MAX_ENTRIES];
    word_t     t_sdata    [MAX_ENTRIES];
    logic      t_from_mem [MAX_ENTRIES];
    logic      t_gr_we    [MAX_ENTRIES];
    reg_idx_t  t_dest     [MAX_ENTRIES];
    logic      t_ertn     [MAX_ENTRIES];
    word_t     exp_data   [MAX_ENTRIES];
    int        n_entries;

    logic [7:0] ref_mem [0:`RAM_WORDS*4-1];    // byte-wide reference memory
    int         wb_queue [$];                   // entries still owed to rf_we
    logic       mem_v;
    logic       wb_v;
    int         mem_e;
    int         wb_e;
    int         cur_entry;
    logic       present;
    logic       accepted;
    integer     seed;
    int         err_count;
    int         timeout_count;

    tb_clock u_clock (.clk(clk));

    mem_backend dut (.*);

    task automatic add_entry(input mem_type_t mt, input logic st, input word_t addr,
                             input word_t sdata, input logic from_mem, input logic gr_we,
                             input reg_idx_t dest, input logic ertn);
        t_type[n_entries]     = mt;
        t_store[n_entries]    = st;
        t_addr[n_entries]     = addr;
        t_sdata[n_entries]    = sdata;
        t_from_mem[n_entries] = from_mem;
        t_gr_we[n_entries]    = gr_we;
        t_dest[n_entries]     = dest;
        t_ertn[n_entries]     = ertn;
        n_entries++;
    endtask

    task automatic add_store(input mem_type_t mt, input word_t addr, input word_t data);
        add_entry(mt, 1'b1, addr, data, 1'b0, 1'b0, 5'd0, 1'b0);
    endtask

    task automatic add_load(input mem_type_t mt, input word_t addr, input reg_idx_t dest);
        add_entry(mt, 1'b0, addr, 32'h0, 1'b1, 1'b1, dest, 1'b0);
    endtask

    task automatic add_alu(input word_t value, input logic gr_we, input reg_idx_t dest,
                           input logic ertn);
        add_entry(`MT_W, 1'b0, value, 32'h0, 1'b0, gr_we, dest, ertn);
    endtask

    task automatic build_table();
        n_entries = 0;
        add_store(`MT_W, 32'h0000_0100, 32'h1122_3344);
        add_store(`MT_H, 32'h0000_0104, 32'h0000_a1b2);
        add_store(`MT_H, 32'h0000_0106, 32'h5555_c3d4);     // upper half ignored
        for (int k = 0; k < 4; k++) begin
            add_store(`MT_B, 32'h108 + k, 32'hffff_ff80 + k * 32'h11);
        end
        add_store(`MT_W, 32'h0000_010c, 32'hdead_beef);
        add_store(`MT_B, 32'h0000_010d, 32'h0000_0077);
        add_store(`MT_H, 32'h0000_010e, 32'h0000_8899);
        add_store(`MT_W, 32'h0000_0110, 32'hcafe_f00d);
        add_store(`MT_H, 32'h0000_0110, 32'h0000_1357);
        add_store(`MT_B, 32'h0000_0113, 32'h0000_00e4);
        for (int k = 0; k < 5; k++) begin
            add_load(`MT_W, 32'h100 + 4 * k, reg_idx_t'(k + 1));
        end
        add_load(`MT_W, 32'h8000_010c, 5'd6);               // aliases above RAM range
        for (int k = 0; k < 4; k++) begin
            add_load(`MT_B,  32'h108 + k, reg_idx_t'(k + 8));
            add_load(`MT_BU, 32'h108 + k, reg_idx_t'(k + 12));
            add_load(`MT_B,  32'h10c + k, reg_idx_t'(k + 16));
            add_load(`MT_BU, 32'h10c + k, reg_idx_t'(k + 20));
        end
        for (int k = 0; k < 4; k += 2) begin
            add_load(`MT_H,  32'h104 + k, reg_idx_t'(k + 24));
            add_load(`MT_HU, 32'h104 + k, reg_idx_t'(k + 25));
            add_load(`MT_H,  32'h110 + k, reg_idx_t'(k + 28));
            add_load(`MT_HU, 32'h110 + k, reg_idx_t'(k + 29));
        end
        add_alu(32'h0000_0abc, 1'b1, 5'd20, 1'b0);
        add_alu(32'hffff_0001, 1'b0, 5'd21, 1'b0);
        add_alu(32'h1234_5678, 1'b1, 5'd22, 1'b0);
        add_alu(32'h0000_0000, 1'b0, 5'd0, 1'b1);            // back-to-back ertn
        add_alu(32'h0000_0000, 1'b0, 5'd0, 1'b1);
        add_alu(32'h8765_4321, 1'b1, 5'd23, 1'b0);
        add_store(`MT_W, 32'h0000_0100, 32'h0f0f_0f0f);
        add_load(`MT_W, 32'h0000_0100, 5'd25);               // store then load next cycle
    endtask

    function automatic pc_t entry_pc(input int i);
        return pc_t'(32'h1c00_0000 + i * 4);
    endfunction

    function automatic word_t ref_load(input mem_type_t mt, input int a);
        int          wa;
        int          ha;
        word_t       w;
        logic [15:0] h;
        logic [7:0]  b;
        wa = a & ~3;
        ha = a & ~1;
        w  = {ref_mem[wa + 3], ref_mem[wa + 2], ref_mem[wa + 1], ref_mem[wa]};
        h  = {ref_mem[ha + 1], ref_mem[ha]};
        b  = ref_mem[a];
        case (mt)
            `MT_H:   return word_t'($signed(h));
            `MT_HU:  return word_t'(h);
            `MT_B:   return word_t'($signed(b));
            `MT_BU:  return word_t'(b);
            default: return w;
        endcase
    endfunction

    task automatic report_error(input string msg);
        err_count++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    task automatic accept_entry(input int i);
        int    a;
        word_t d;
        a = t_addr[i] & (`RAM_WORDS * 4 - 1);
        d = t_sdata[i];
        if (t_store[i]) begin
            case (t_type[i][1:0])
                2'b01: begin
                    ref_mem[a & ~1]       = d[7:0];
                    ref_mem[(a & ~1) + 1] = d[15:8];
                end
                2'b10:   ref_mem[a] = d[7:0];
                default: begin
                    for (int k = 0; k < 4; k++) begin
                        ref_mem[(a & ~3) + k] = d[8*k +: 8];
                    end
                end
            endcase
        end
        if (t_gr_we[i]) begin
            exp_data[i] = t_from_mem[i] ? ref_load(t_type[i], a) : t_addr[i];
            wb_queue.push_back(i);
        end
    endtask

    task automatic check_outputs();
        int   e;
        logic exp_fwd;
        logic exp_flush;
        logic exp_we;
        exp_fwd   = mem_v && t_gr_we[mem_e];
        exp_flush = mem_v && t_ertn[mem_e];
        exp_we    = wb_v && t_gr_we[wb_e] && !commit_stall;
        if (mem_fwd_valid !== exp_fwd) begin
            report_error($sformatf("mem_fwd_valid %b, expected %b", mem_fwd_valid, exp_fwd));
        end else if (exp_fwd && (mem_fwd_dest !== t_dest[mem_e] ||
                                 mem_fwd_data !== exp_data[mem_e])) begin
            report_error($sformatf("forward r%0d=%h, expected r%0d=%h", mem_fwd_dest,
                                   mem_fwd_data, t_dest[mem_e], exp_data[mem_e]));
        end
        if (ertn_flush !== exp_flush) begin
            report_error($sformatf("ertn_flush %b, expected %b", ertn_flush, exp_flush));
        end
        if (rf_we !== exp_we) begin
            report_error($sformatf("rf_we %b, expected %b", rf_we, exp_we));
        end
        if (rf_we === 1'b1) begin
            if (wb_queue.size() == 0) begin
                report_error($sformatf("unexpected rf_we to r%0d", rf_waddr));
            end else begin
                e = wb_queue.pop_front();
                if (rf_waddr !== t_dest[e] || rf_wdata !== exp_data[e] ||
                    wb_pc !== entry_pc(e)) begin
                    report_error($sformatf("write r%0d=%h pc %h, expected r%0d=%h pc %h",
                                           rf_waddr, rf_wdata, wb_pc, t_dest[e],
                                           exp_data[e], entry_pc(e)));
                end
            end
        end
    endtask

    // drive on the falling edge and sample just after
    task automatic run_cycle();
        logic wb_allowin_m;
        logic mem_allowin_m;
        @(negedge clk);
        commit_stall = (($random(seed) & 3) == 0);
        ex_valid     = present;
        if (present) begin
            ex_pc           = entry_pc(cur_entry);
            ex_gr_we        = t_gr_we[cur_entry];
            ex_res_from_mem = t_from_mem[cur_entry];
            ex_mem_we       = t_store[cur_entry];
            ex_mem_type     = t_type[cur_entry];
            ex_alu_result   = t_addr[cur_entry];
            ex_store_data   = t_sdata[cur_entry];
            ex_dest         = t_dest[cur_entry];
            ex_ertn         = t_ertn[cur_entry];
        end
        #1;
        check_outputs();
        wb_allowin_m  = !wb_v || !commit_stall;
        mem_allowin_m = !mem_v || wb_allowin_m;
        if (ex_allowin !== mem_allowin_m) begin
            report_error($sformatf("ex_allowin %b, expected %b", ex_allowin, mem_allowin_m));
        end
        if (ex_valid && ex_allowin) begin
            accept_entry(cur_entry);
            accepted = 1'b1;
        end
        if (wb_allowin_m) begin
            wb_v = mem_v;
            wb_e = mem_e;
        end
        if (mem_allowin_m) begin
            mem_v = ex_valid;
            mem_e = cur_entry;
        end
    endtask

    initial begin
        int wait_cycles;
        seed            = 32'he02;
        err_count       = 0;
        timeout_count   = 0;
        resetn          = 1'b0;
        ex_valid        = 1'b0;
        ex_pc           = '0;
        ex_gr_we        = 1'b0;
        ex_res_from_mem = 1'b0;
        ex_mem_we       = 1'b0;
        ex_mem_type     = `MT_W;
        ex_alu_result   = '0;
        ex_store_data   = '0;
        ex_dest         = '0;
        ex_ertn         = 1'b0;
        commit_stall    = 1'b0;
        mem_v           = 1'b0;
        wb_v            = 1'b0;
        mem_e           = 0;
        wb_e            = 0;
        cur_entry       = 0;
        present         = 1'b0;
        accepted        = 1'b0;
        build_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        for (int i = 0; i < n_entries && timeout_count == 0; i++) begin
            cur_entry   = i;
            present     = 1'b1;
            accepted    = 1'b0;
            wait_cycles = 0;
            while (!accepted && timeout_count == 0) begin
                run_cycle();
                wait_cycles++;
                if (!accepted && wait_cycles >= ACCEPT_LIMIT) begin
                    $display("timeout: entry %0d was never accepted, ex_allowin stayed low", i);
                    timeout_count++;
                end
            end
        end
        present     = 1'b0;
        wait_cycles = 0;
        while (timeout_count == 0 && (wb_queue.size() != 0 || mem_v || wb_v)) begin
            run_cycle();
            wait_cycles++;
            if (wait_cycles >= DRAIN_LIMIT) begin
                $display("timeout: pipeline hung with %0d writebacks missing", wb_queue.size());
                timeout_count++;
            end
        end
        if (timeout_count == 0) begin
            repeat (4) run_cycle();     // idle tail checks for stray writes
        end
        $display("errors: %0d mismatches, %0d timeouts", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
